//--- rtl/nocCfg.svh
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

// Flit id field
`define FLIT_ID_W 3

// Packet length and hold count
`define LEN_W 12

// Flit payload
`define DATA_W 32

// Id code of a header flit
`define HDR_ID 1

`endif

//--- rtl/nocPkg.sv
`include "nocCfg.svh"

package nocPkg;

  // One-hot grant states, bit 0 is idle
  typedef enum logic [5:0] {
    ST_IDLE = 6'b000001,
    ST_L    = 6'b000010,
    ST_N    = 6'b000100,
    ST_E    = 6'b001000,
    ST_W    = 6'b010000,
    ST_S    = 6'b100000
  } arbState_t;

  typedef enum logic [`FLIT_ID_W-1:0] {
    FK_NONE = `FLIT_ID_W'(0),
    FK_HEAD = `FLIT_ID_W'(`HDR_ID),
    FK_BODY = `FLIT_ID_W'(2),
    FK_TAIL = `FLIT_ID_W'(3)
  } flitKind_t;

  // Port index of a grant state, L=0 through S=4
  function automatic logic [2:0] portOf(arbState_t s);
    case (s)
      ST_N:    return 3'd1;
      ST_E:    return 3'd2;
      ST_W:    return 3'd3;
      ST_S:    return 3'd4;
      default: return 3'd0;
    endcase
  endfunction

endpackage

//--- rtl/flitIngress.sv
`timescale 1ns/1ps
`include "nocCfg.svh"

module flitIngress import nocPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inValid,
  input  logic [`FLIT_ID_W-1:0] inFlitId,
  input  logic [`DATA_W-1:0]    inData,
  output logic                  req,
  output logic [`FLIT_ID_W-1:0] flitId,
  output logic [`LEN_W-1:0]     length,
  output logic [`DATA_W-1:0]    data
);

  logic isHeader;

  assign isHeader = inValid && (flitKind_t'(inFlitId) == FK_HEAD);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      req    <= 1'b0;
      flitId <= FK_NONE;
      length <= '0;
    end
    else
    begin
      req    <= inValid;
      flitId <= inValid ? inFlitId : FK_NONE; // Empty slot reads as no flit
      // Length stays put until the next header
      if (isHeader)
        length <= inData[`LEN_W-1:0];
    end
  end

  always_ff @(posedge clk)
    data <= inData;

  // Sender must only present known flit kinds
  assert property (@(posedge clk) disable iff (rst)
    inValid |-> (inFlitId inside {FK_NONE, FK_HEAD, FK_BODY, FK_TAIL}))
    else $error("flitIngress: illegal flit id %0h", inFlitId);

endmodule

//--- rtl/holdTimer.sv
`timescale 1ns/1ps
`include "nocCfg.svh"

module holdTimer import nocPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`FLIT_ID_W-1:0] flitId,
  input  logic [`LEN_W-1:0]     length,
  input  logic                  run,
  output logic                  timesUp
);

  logic [`LEN_W-1:0] count;
  logic [`LEN_W-1:0] limit;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '1; // Never matches the cleared limit
      limit <= '0;
    end
    else
    begin
      if (flitKind_t'(flitId) == FK_HEAD)
        limit <= length;
      if (!run)
        count <= '0; // Idle or not holding
      else
        count <= count + 1'b1;
    end
  end

  // Combinational so the arbiter sees it in the same cycle
  assign timesUp = (count == limit);

endmodule

//--- rtl/portArbiter.sv
`timescale 1ns/1ps
`include "nocCfg.svh"

module portArbiter import nocPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  reqL,
  input  logic                  reqN,
  input  logic                  reqE,
  input  logic                  reqW,
  input  logic                  reqS,
  input  logic [`FLIT_ID_W-1:0] flitIdL,
  input  logic [`FLIT_ID_W-1:0] flitIdN,
  input  logic [`FLIT_ID_W-1:0] flitIdE,
  input  logic [`FLIT_ID_W-1:0] flitIdW,
  input  logic [`FLIT_ID_W-1:0] flitIdS,
  input  logic [`LEN_W-1:0]     lengthL,
  input  logic [`LEN_W-1:0]     lengthN,
  input  logic [`LEN_W-1:0]     lengthE,
  input  logic [`LEN_W-1:0]     lengthW,
  input  logic [`LEN_W-1:0]     lengthS,
  output arbState_t             state
);

  arbState_t  nextState;
  logic [4:0] reqV;
  logic [4:0] timesUp;
  logic [4:0] run;
  logic [2:0] holder;

  // First requester found scanning L, N, E, W, S from position first
  function automatic arbState_t nextGrant(input logic [4:0] reqs, input logic [2:0] first);
    arbState_t  pick;
    logic [2:0] idx;
    pick = ST_IDLE;
    for (int i = 4; i >= 0; i--)
    begin
      idx = 3'((first + i) % 5);
      if (reqs[idx])
        pick = arbState_t'(6'b000010 << idx); // Later hits overwrite, so nearest wins
    end
    return pick;
  endfunction

  assign reqV   = {reqS, reqW, reqE, reqN, reqL};
  assign holder = portOf(state);

  holdTimer u_timerL (
    .clk(clk), .rst(rst), .flitId(flitIdL), .length(lengthL),
    .run(run[0]), .timesUp(timesUp[0])
  );
  holdTimer u_timerN (
    .clk(clk), .rst(rst), .flitId(flitIdN), .length(lengthN),
    .run(run[1]), .timesUp(timesUp[1])
  );
  holdTimer u_timerE (
    .clk(clk), .rst(rst), .flitId(flitIdE), .length(lengthE),
    .run(run[2]), .timesUp(timesUp[2])
  );
  holdTimer u_timerW (
    .clk(clk), .rst(rst), .flitId(flitIdW), .length(lengthW),
    .run(run[3]), .timesUp(timesUp[3])
  );
  holdTimer u_timerS (
    .clk(clk), .rst(rst), .flitId(flitIdS), .length(lengthS),
    .run(run[4]), .timesUp(timesUp[4])
  );

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ST_IDLE;
    else
      state <= nextState;
  end

  always_comb
  begin
    run       = '0;
    nextState = ST_IDLE;
    case (state)
      ST_IDLE:
        nextState = nextGrant(reqV, 3'd0); // Fixed order from idle
      ST_L, ST_N, ST_E, ST_W, ST_S:
      begin
        if (reqV[holder] && !timesUp[holder])
        begin
          run[holder] = 1'b1;
          nextState   = state;
        end
        else
          nextState = nextGrant(reqV, holder + 3'd1); // Rotate past the holder
      end
      default:
        nextState = ST_IDLE;
    endcase
  end

  assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("portArbiter: state %0h not one-hot", state);

  // A timer only runs for the port that holds the grant
  assert property (@(posedge clk) disable iff (rst)
    (run & ~state[5:1]) == 5'b0)
    else $error("portArbiter: run %0h outside state %0h", run, state);

endmodule

//--- rtl/flitEgress.sv
`timescale 1ns/1ps
`include "nocCfg.svh"

module flitEgress import nocPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  arbState_t             state,
  input  logic                  reqL,
  input  logic                  reqN,
  input  logic                  reqE,
  input  logic                  reqW,
  input  logic                  reqS,
  input  logic [`DATA_W-1:0]    dataL,
  input  logic [`DATA_W-1:0]    dataN,
  input  logic [`DATA_W-1:0]    dataE,
  input  logic [`DATA_W-1:0]    dataW,
  input  logic [`DATA_W-1:0]    dataS,
  input  logic [`FLIT_ID_W-1:0] flitIdL,
  input  logic [`FLIT_ID_W-1:0] flitIdN,
  input  logic [`FLIT_ID_W-1:0] flitIdE,
  input  logic [`FLIT_ID_W-1:0] flitIdW,
  input  logic [`FLIT_ID_W-1:0] flitIdS,
  output logic                  outValid,
  output logic [`DATA_W-1:0]    outData,
  output logic [`FLIT_ID_W-1:0] outFlitId,
  output logic [2:0]            outPort
);

  logic [4:0]                      reqV;
  logic [4:0][`DATA_W-1:0]         dataV;
  logic [4:0][`FLIT_ID_W-1:0]      idV;
  logic [2:0]                      sel;

  assign reqV  = {reqS, reqW, reqE, reqN, reqL};
  assign dataV = {dataS, dataW, dataE, dataN, dataL};
  assign idV   = {flitIdS, flitIdW, flitIdE, flitIdN, flitIdL};
  assign sel   = portOf(state); // Idle points at L, masked below

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outPort  <= 3'd0;
    end
    else
    begin
      outValid <= (state != ST_IDLE) && reqV[sel];
      outPort  <= sel;
    end
  end

  always_ff @(posedge clk)
  begin
    outData   <= dataV[sel];
    outFlitId <= idV[sel];
  end

endmodule

//--- rtl/routerOutputPort.sv
`timescale 1ns/1ps
`include "nocCfg.svh"

module routerOutputPort import nocPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inValidL,
  input  logic [`FLIT_ID_W-1:0] inFlitIdL,
  input  logic [`DATA_W-1:0]    inDataL,
  input  logic                  inValidN,
  input  logic [`FLIT_ID_W-1:0] inFlitIdN,
  input  logic [`DATA_W-1:0]    inDataN,
  input  logic                  inValidE,
  input  logic [`FLIT_ID_W-1:0] inFlitIdE,
  input  logic [`DATA_W-1:0]    inDataE,
  input  logic                  inValidW,
  input  logic [`FLIT_ID_W-1:0] inFlitIdW,
  input  logic [`DATA_W-1:0]    inDataW,
  input  logic                  inValidS,
  input  logic [`FLIT_ID_W-1:0] inFlitIdS,
  input  logic [`DATA_W-1:0]    inDataS,
  output logic [4:0]            grant,
  output logic                  outValid,
  output logic [`DATA_W-1:0]    outData,
  output logic [`FLIT_ID_W-1:0] outFlitId,
  output logic [2:0]            outPort
);

  logic                  reqL, reqN, reqE, reqW, reqS;
  logic [`FLIT_ID_W-1:0] flitIdL, flitIdN, flitIdE, flitIdW, flitIdS;
  logic [`LEN_W-1:0]     lengthL, lengthN, lengthE, lengthW, lengthS;
  logic [`DATA_W-1:0]    dataL, dataN, dataE, dataW, dataS;
  arbState_t             arbState;

  flitIngress u_ingL (
    .clk(clk), .rst(rst), .inValid(inValidL), .inFlitId(inFlitIdL), .inData(inDataL),
    .req(reqL), .flitId(flitIdL), .length(lengthL), .data(dataL)
  );
  flitIngress u_ingN (
    .clk(clk), .rst(rst), .inValid(inValidN), .inFlitId(inFlitIdN), .inData(inDataN),
    .req(reqN), .flitId(flitIdN), .length(lengthN), .data(dataN)
  );
  flitIngress u_ingE (
    .clk(clk), .rst(rst), .inValid(inValidE), .inFlitId(inFlitIdE), .inData(inDataE),
    .req(reqE), .flitId(flitIdE), .length(lengthE), .data(dataE)
  );
  flitIngress u_ingW (
    .clk(clk), .rst(rst), .inValid(inValidW), .inFlitId(inFlitIdW), .inData(inDataW),
    .req(reqW), .flitId(flitIdW), .length(lengthW), .data(dataW)
  );
  flitIngress u_ingS (
    .clk(clk), .rst(rst), .inValid(inValidS), .inFlitId(inFlitIdS), .inData(inDataS),
    .req(reqS), .flitId(flitIdS), .length(lengthS), .data(dataS)
  );

  portArbiter u_arb (
    .clk(clk), .rst(rst),
    .reqL(reqL), .reqN(reqN), .reqE(reqE), .reqW(reqW), .reqS(reqS),
    .flitIdL(flitIdL), .flitIdN(flitIdN), .flitIdE(flitIdE),
    .flitIdW(flitIdW), .flitIdS(flitIdS),
    .lengthL(lengthL), .lengthN(lengthN), .lengthE(lengthE),
    .lengthW(lengthW), .lengthS(lengthS),
    .state(arbState)
  );

  flitEgress u_egr (
    .clk(clk), .rst(rst), .state(arbState),
    .reqL(reqL), .reqN(reqN), .reqE(reqE), .reqW(reqW), .reqS(reqS),
    .dataL(dataL), .dataN(dataN), .dataE(dataE), .dataW(dataW), .dataS(dataS),
    .flitIdL(flitIdL), .flitIdN(flitIdN), .flitIdE(flitIdE),
    .flitIdW(flitIdW), .flitIdS(flitIdS),
    .outValid(outValid), .outData(outData), .outFlitId(outFlitId), .outPort(outPort)
  );

  // Grant bits are the one-hot port states, idle bit dropped
  assign grant = arbState[5:1];

endmodule

//--- bench/tbRouterOutputPort.sv
`timescale 1ns/1ps
`include "nocCfg.svh"

module tbRouterOutputPort;

  localparam int TOTAL_FLITS = 65;  // 20 + 25 + 10 + 10 over the packet tests
  localparam int CYCLES_PER_FLIT = 20;
  localparam int WATCHDOG_NS = (TOTAL_FLITS * CYCLES_PER_FLIT + 100) * 100;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  inValid [5];
  logic [`FLIT_ID_W-1:0] inFlitId [5];
  logic [`DATA_W-1:0]    inData [5];
  logic [4:0]            grant;
  logic                  outValid;
  logic [`DATA_W-1:0]    outData;
  logic [`FLIT_ID_W-1:0] outFlitId;
  logic [2:0]            outPort;

  integer seed = 32'h3bd72e4a;

  // Each entry is {flit id, payload}
  logic [`FLIT_ID_W+`DATA_W-1:0] expQ [5][$];
  logic [`FLIT_ID_W+`DATA_W-1:0] gotQ [5][$];
  int orderQ [$];  // Winning port of every output flit

  routerOutputPort u_dut (
    .clk(clk), .rst(rst),
    .inValidL(inValid[0]), .inFlitIdL(inFlitId[0]), .inDataL(inData[0]),
    .inValidN(inValid[1]), .inFlitIdN(inFlitId[1]), .inDataN(inData[1]),
    .inValidE(inValid[2]), .inFlitIdE(inFlitId[2]), .inDataE(inData[2]),
    .inValidW(inValid[3]), .inFlitIdW(inFlitId[3]), .inDataW(inData[3]),
    .inValidS(inValid[4]), .inFlitIdS(inFlitId[4]), .inDataS(inData[4]),
    .grant(grant), .outValid(outValid), .outData(outData),
    .outFlitId(outFlitId), .outPort(outPort)
  );

  always #50 clk = ~clk;

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the tests did not finish in time");
    $display("TEST FAIL");
    $fatal(1, "Run stopped by the watchdog");
  end

  task automatic failWith(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Check failed");
  endtask

  // Output registers settle after the rising edge
  always @(negedge clk)
  begin
    if (!rst && outValid)
    begin
      assert (outPort < 3'd5)
        else failWith($sformatf("[ERROR] outPort = %h, not a port index", outPort));
      assert (gotQ[outPort].size() < expQ[outPort].size())
        else failWith($sformatf("[ERROR] outPort = %h sent an extra flit, outData = %h",
                                outPort, outData));
      gotQ[outPort].push_back({outFlitId, outData});
      orderQ.push_back(int'(outPort));
    end
  end

  task automatic clearScoreboard();
    for (int p = 0; p < 5; p++)
    begin
      expQ[p].delete();
      gotQ[p].delete();
    end
    orderQ.delete();
  endtask

  // Holds each flit until the port's grant bit is seen
  task automatic sendPacket(input int p, input int nFlits, input logic [`LEN_W-1:0] len);
    logic [`DATA_W-1:0]    word;
    logic [`FLIT_ID_W-1:0] id;
    for (int i = 0; i < nFlits; i++)
    begin
      if (i == 0)
        id = `FLIT_ID_W'(`HDR_ID);
      else if (i == nFlits - 1)
        id = `FLIT_ID_W'(3);  // Tail
      else
        id = `FLIT_ID_W'(2);
      word = $random(seed);
      if (i == 0)
        word[`LEN_W-1:0] = len;
      expQ[p].push_back({id, word});
      inValid[p]  = 1'b1;
      inFlitId[p] = id;
      inData[p]   = word;
      do
        @(negedge clk);
      while (!grant[p]);
    end
    inValid[p] = 1'b0;
  endtask

  task automatic waitDrained();
    int missing;
    do
    begin
      @(posedge clk);
      missing = 0;
      for (int p = 0; p < 5; p++)
        if (gotQ[p].size() < expQ[p].size())
          missing++;
    end
    while (missing != 0);
    @(negedge clk);
  endtask

  task automatic compareQueues();
    logic [`FLIT_ID_W+`DATA_W-1:0] got;
    logic [`FLIT_ID_W+`DATA_W-1:0] exp;
    for (int p = 0; p < 5; p++)
    begin
      for (int i = 0; i < expQ[p].size(); i++)
      begin
        got = gotQ[p][i];
        exp = expQ[p][i];
        assert (got[`DATA_W-1:0] == exp[`DATA_W-1:0])
          else failWith($sformatf("[ERROR] outData port %0d flit %0d = %h, expected %h",
                                  p, i, got[`DATA_W-1:0], exp[`DATA_W-1:0]));
        assert (got[`FLIT_ID_W+`DATA_W-1:`DATA_W] == exp[`FLIT_ID_W+`DATA_W-1:`DATA_W])
          else failWith($sformatf("[ERROR] outFlitId port %0d flit %0d = %h, expected %h",
                                  p, i, got[`FLIT_ID_W+`DATA_W-1:`DATA_W],
                                  exp[`FLIT_ID_W+`DATA_W-1:`DATA_W]));
      end
    end
  endtask

  // A new winner must be the first port with flits left after the previous one
  task automatic checkRotation();
    int rem [5];
    int prev;
    int want;
    int start;
    int p;
    int q;
    for (int k = 0; k < 5; k++)
      rem[k] = expQ[k].size();
    prev = -1;
    for (int k = 0; k < orderQ.size(); k++)
    begin
      p = orderQ[k];
      if (p != prev)
      begin
        start = (prev < 0) ? 0 : prev + 1;  // From idle the scan starts at Local
        want = -1;
        for (int i = 0; i < 5; i++)
        begin
          q = (start + i) % 5;
          if (rem[q] > 0 && want < 0)
            want = q;
        end
        assert (p == want)
          else failWith($sformatf("[ERROR] outPort = %h after port %0d, expected %h",
                                  p, prev, want));
      end
      rem[p]--;
      prev = p;
    end
  endtask

  task automatic waitIdle();
    int waited;
    waited = 0;
    while ((grant != 5'b0 || outValid) && waited < 10)
    begin
      @(negedge clk);
      waited++;
    end
    assert (grant == 5'b0 && !outValid)
      else failWith($sformatf("[ERROR] grant = %h, outValid = %h, expected both 0 at idle",
                              grant, outValid));
    repeat (3)
    begin
      @(negedge clk);
      assert (grant == 5'b0 && !outValid)
        else failWith($sformatf("[ERROR] grant = %h, outValid = %h while nobody requests",
                                grant, outValid));
    end
  endtask

  task automatic checkFirstGrant();
    do
      @(negedge clk);
    while (grant == 5'b0);
    assert (grant == 5'b00001)
      else failWith($sformatf("[ERROR] grant = %h on first grant, expected 01", grant));
  endtask

  task automatic idleAfterReset();
    repeat (5)
    begin
      @(negedge clk);
      assert (grant == 5'b0 && !outValid)
        else failWith($sformatf("[ERROR] grant = %h, outValid = %h after reset",
                                grant, outValid));
    end
  endtask

  task automatic singlePortPackets();
    for (int p = 0; p < 5; p++)
    begin
      clearScoreboard();
      sendPacket(p, 4, 12'd8);
      waitDrained();
      compareQueues();
      waitIdle();
    end
  endtask

  task automatic allPortsRotation();
    clearScoreboard();
    fork
      checkFirstGrant();
      sendPacket(0, 5, 12'd1);
      sendPacket(1, 5, 12'd1);
      sendPacket(2, 5, 12'd1);
      sendPacket(3, 5, 12'd1);
      sendPacket(4, 5, 12'd1);
    join
    waitDrained();
    compareQueues();
    checkRotation();
    waitIdle();
  endtask

  // Local is cut short by its length, North must get in between
  task automatic shortHoldPreempt();
    int firstN;
    int lastL;
    clearScoreboard();
    fork
      sendPacket(0, 6, 12'd1);
      sendPacket(1, 4, 12'd8);
    join
    waitDrained();
    compareQueues();
    checkRotation();
    firstN = -1;
    lastL = -1;
    for (int k = 0; k < orderQ.size(); k++)
    begin
      if (orderQ[k] == 1 && firstN < 0)
        firstN = k;
      if (orderQ[k] == 0)
        lastL = k;
    end
    assert (firstN >= 0 && firstN < lastL)
      else failWith("Local kept the grant for its whole packet, North never got in between");
    waitIdle();
  endtask

  task automatic returnToIdle();
    clearScoreboard();
    fork
      sendPacket(0, 2, 12'd4);
      sendPacket(1, 2, 12'd4);
      sendPacket(2, 2, 12'd4);
      sendPacket(3, 2, 12'd4);
      sendPacket(4, 2, 12'd4);
    join
    waitDrained();
    compareQueues();
    waitIdle();
  endtask

  initial
  begin
    rst = 1'b1;
    for (int p = 0; p < 5; p++)
    begin
      inValid[p]  = 1'b0;
      inFlitId[p] = '0;
      inData[p]   = '0;
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;

    idleAfterReset();
    singlePortPackets();
    allPortsRotation();
    shortHoldPreempt();
    returnToIdle();

    $display("TEST PASS");
    $finish;
  end

endmodule

//--- sources.f
+incdir+rtl
rtl/nocPkg.sv
rtl/flitIngress.sv
rtl/holdTimer.sv
rtl/portArbiter.sv
rtl/flitEgress.sv
rtl/routerOutputPort.sv
bench/tbRouterOutputPort.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module tbRouterOutputPort \
  || { echo "Build failed"; exit 1; }
out=$(./obj_dir/VtbRouterOutputPort 2>&1)
echo "$out"
echo "$out" | grep -qx "TEST PASS" && exit 0 || exit 1
